/* mem_dual_bank.f */
src/mem_pkg.sv
src/mem_bram.sv
src/mem_port_router.sv
src/mem_dual_bank.sv
verif/tb_mem_dual_bank.sv

/* Makefile */
# Verilator build and run of the dual-bank memory testbench

SIM := obj_dir/Vtb_mem_dual_bank

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_mem_dual_bank -f mem_dual_bank.f -Mdir obj_dir
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* verif/tb_mem_dual_bank.sv */
`timescale 1ns/10ps

// Directed testbench for the two-bank memory with a word-level reference model
module tb_mem_dual_bank;

  localparam int RANDOM_OPS = 300;
  localparam int WAIT_LIMIT = 64;
  // Directed tests need a few hundred cycles, a random op at most a dozen
  localparam int RUN_CYCLES = 500 + RANDOM_OPS * 12;

  logic           clk = 1'b0;
  logic           rst_n;
  mem_pkg::addr_t araddr;
  logic           arvalid;
  logic           arready;
  mem_pkg::data_t rdata;
  logic           rvalid;
  logic           rready;
  mem_pkg::addr_t awaddr;
  logic           awvalid;
  logic           awready;
  mem_pkg::data_t wdata;
  mem_pkg::strb_t wstrb;
  logic           wvalid;
  logic           wready;

  // Reference memory, indexed by byte-address bits 11:2
  mem_pkg::data_t model [1024];
  logic [31:0]    lcg_state = 32'he9fa;
  int             errors = 0;
  int             checks = 0;

  mem_dual_bank i_mem_dual_bank (.*);

  always #2 clk = ~clk;

  // LCG step, high half folded into the weak low bits
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  task automatic check_data(string name, mem_pkg::data_t exp, mem_pkg::data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_stall(string what);
    errors++;
    $display("%s: handshake did not complete within %0d cycles", what, WAIT_LIMIT);
  endtask

  // Merge the strobed bytes into the model word
  task automatic model_write(mem_pkg::addr_t addr, mem_pkg::data_t data, mem_pkg::strb_t strb);
    for (int b = 0; b < mem_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        model[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  // Called 1 ns after a rising edge, the write lands on the next edge
  task automatic write_word(mem_pkg::addr_t addr, mem_pkg::data_t data, mem_pkg::strb_t strb);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge clk);
    model_write(addr, data, strb);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // Offer a read, wait for arready and capture the model word at acceptance
  task automatic issue_read(mem_pkg::addr_t addr, output mem_pkg::data_t exp);
    int n;
    n       = 0;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready && n < WAIT_LIMIT) begin
      n++;
      @(negedge clk);
    end
    if (!arready) begin
      report_stall("Read address");
    end
    exp = model[addr[11:2]];
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  // Wait for the response, rready either held high or random per cycle
  task automatic take_resp(string name, mem_pkg::data_t exp, logic rand_ready);
    int          n;
    logic        done;
    logic [31:0] r;
    n    = 0;
    done = 1'b0;
    while (!done && n < WAIT_LIMIT) begin
      r      = lcg_next();
      rready = rand_ready ? r[5] : 1'b1;
      @(negedge clk);
      if (rvalid && rready) begin
        check_data(name, exp, rdata);
        done = 1'b1;
      end
      n++;
      @(posedge clk);
      #1;
    end
    rready = 1'b0;
    if (!done) begin
      report_stall("Read response");
    end
  endtask

  task automatic read_check(string name, mem_pkg::addr_t addr);
    mem_pkg::data_t exp;
    issue_read(addr, exp);
    take_resp(name, exp, 1'b0);
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_bit("reset rvalid", 1'b0, rvalid);
    check_bit("reset arready", 1'b1, arready);
    check_bit("reset awready", 1'b1, awready);
    check_bit("reset wready", 1'b1, wready);
    @(posedge clk);
    #1;
    // Model is all zeros here
    read_check("reset read bank0", 32'h0000_0124);
    read_check("reset read bank1", 32'h0000_0ffc);
  endtask

  task automatic test_bank_split();
    // Same word offset 4 in both banks
    write_word(32'h0000_0010, 32'hb0b0_0010, 4'hf);
    write_word(32'h0000_0810, 32'hb1b1_0810, 4'hf);
    // Upper bits set, lands on word 5 of bank 0
    write_word(32'h5a00_1014, 32'ha1a5_1014, 4'hf);
    read_check("split bank0", 32'h0000_0010);
    read_check("split bank1", 32'h0000_0810);
    read_check("split alias", 32'h0000_0014);
    read_check("split alias bank1", 32'hffff_f810);
  endtask

  task automatic test_strobes();
    int s;
    write_word(32'h0000_0a40, 32'h1122_3344, 4'hf);
    read_check("strobe full", 32'h0000_0a40);
    for (s = 0; s < 16; s++) begin
      write_word(32'h0000_0a40, 32'hf0e1_d2c3 + s * 32'h1111_1111, s[3:0]);
      read_check("strobe pattern", 32'h0000_0a40);
    end
  endtask

  task automatic test_backpressure();
    mem_pkg::data_t exp_a;
    mem_pkg::data_t exp_b;
    mem_pkg::addr_t addr_b;
    addr_b = 32'h0000_0900;
    write_word(32'h0000_0100, 32'haaaa_0100, 4'hf);
    write_word(addr_b, 32'hbbbb_0900, 4'hf);
    rready = 1'b0;
    issue_read(32'h0000_0100, exp_a);
    // Bank 1 read waits behind the held bank 0 response
    araddr  = addr_b;
    arvalid = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit("stall rvalid", 1'b1, rvalid);
      check_bit("stall arready", 1'b0, arready);
      check_data("stall rdata", exp_a, rdata);
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(negedge clk);
    // First response leaves on the edge that takes the second read
    check_bit("release rvalid", 1'b1, rvalid);
    check_bit("release arready", 1'b1, arready);
    check_data("order first", exp_a, rdata);
    exp_b = model[addr_b[11:2]];
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    take_resp("order second", exp_b, 1'b0);
  endtask

  task automatic test_read_during_write();
    mem_pkg::data_t exp_old;
    write_word(32'h0000_0c08, 32'h0123_4567, 4'hf);
    awaddr  = 32'h0000_0c08;
    wdata   = 32'hfedc_ba98;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Read is accepted on the same edge as the write
    issue_read(32'h0000_0c08, exp_old);
    model_write(32'h0000_0c08, 32'hfedc_ba98, 4'hf);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    take_resp("rdw old", exp_old, 1'b0);
    read_check("rdw new", 32'h0000_0c08);
  endtask

  task automatic test_random();
    logic [31:0]    r;
    logic [31:0]    op;
    mem_pkg::addr_t addr;
    mem_pkg::data_t exp;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r  = lcg_next();
      op = lcg_next();
      // Random alias bits and bank, 8 words per bank so reads hit written data
      addr = {r[31:11], 6'b0, r[3:1], r[5:4]};
      if (op[0]) begin
        write_word(addr, lcg_next(), op[4:1]);
      end else begin
        issue_read(addr, exp);
        take_resp("random read", exp, 1'b1);
      end
    end
  endtask

  // Watchdog
  initial begin
    repeat (RUN_CYCLES) @(posedge clk);
    $display("Test timed out after %0d cycles without finishing", RUN_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_n   = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      model[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_bank_split();
    test_strobes();
    test_backpressure();
    test_read_during_write();
    test_random();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* src/mem_dual_bank.sv */
`timescale 1ns/10ps

// Two-bank block-RAM subsystem
// Bank 0 serves byte addresses with bit 11 clear, bank 1 those with it set
module mem_dual_bank (
  input  logic           clk,
  input  logic           rst_n,

  // Read address channel
  input  mem_pkg::addr_t araddr,
  input  logic           arvalid,
  output logic           arready,

  // Read data channel
  output mem_pkg::data_t rdata,
  output logic           rvalid,
  input  logic           rready,

  // Write address and data channels
  input  mem_pkg::addr_t awaddr,
  input  logic           awvalid,
  output logic           awready,
  input  mem_pkg::data_t wdata,
  input  mem_pkg::strb_t wstrb,
  input  logic           wvalid,
  output logic           wready
);

  // Bank 0 side
  mem_pkg::word_addr_t b0_raddr;
  logic                b0_arvalid;
  logic                b0_arready;
  mem_pkg::data_t      b0_rdata;
  logic                b0_rvalid;
  logic                b0_rready;
  logic                b0_we;
  mem_pkg::word_addr_t b0_waddr;
  mem_pkg::data_t      b0_wdata;
  mem_pkg::strb_t      b0_wstrb;

  // Bank 1 side
  mem_pkg::word_addr_t b1_raddr;
  logic                b1_arvalid;
  logic                b1_arready;
  mem_pkg::data_t      b1_rdata;
  logic                b1_rvalid;
  logic                b1_rready;
  logic                b1_we;
  mem_pkg::word_addr_t b1_waddr;
  mem_pkg::data_t      b1_wdata;
  mem_pkg::strb_t      b1_wstrb;

  // Address decode, write steering and response ordering
  mem_port_router i_router (
    .clk        (clk),
    .rst_n      (rst_n),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .b0_raddr   (b0_raddr),
    .b0_arvalid (b0_arvalid),
    .b0_arready (b0_arready),
    .b0_rdata   (b0_rdata),
    .b0_rvalid  (b0_rvalid),
    .b0_rready  (b0_rready),
    .b0_we      (b0_we),
    .b0_waddr   (b0_waddr),
    .b0_wdata   (b0_wdata),
    .b0_wstrb   (b0_wstrb),
    .b1_raddr   (b1_raddr),
    .b1_arvalid (b1_arvalid),
    .b1_arready (b1_arready),
    .b1_rdata   (b1_rdata),
    .b1_rvalid  (b1_rvalid),
    .b1_rready  (b1_rready),
    .b1_we      (b1_we),
    .b1_waddr   (b1_waddr),
    .b1_wdata   (b1_wdata),
    .b1_wstrb   (b1_wstrb)
  );

  // Lower bank
  mem_bram i_bank0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr   (b0_raddr),
    .arvalid (b0_arvalid),
    .arready (b0_arready),
    .rdata   (b0_rdata),
    .rvalid  (b0_rvalid),
    .rready  (b0_rready),
    .we      (b0_we),
    .waddr   (b0_waddr),
    .wdata   (b0_wdata),
    .wstrb   (b0_wstrb)
  );

  // Upper bank
  mem_bram i_bank1 (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr   (b1_raddr),
    .arvalid (b1_arvalid),
    .arready (b1_arready),
    .rdata   (b1_rdata),
    .rvalid  (b1_rvalid),
    .rready  (b1_rready),
    .we      (b1_we),
    .waddr   (b1_waddr),
    .wdata   (b1_wdata),
    .wstrb   (b1_wstrb)
  );

endmodule

/* src/mem_port_router.sv */
`timescale 1ns/10ps

// Two-bank router
// Steers reads and writes by address bit BANK_SEL_BIT,
// merges the bank read responses back into one ordered stream
module mem_port_router (
  input  logic                clk,
  input  logic                rst_n,

  // Upstream read address channel
  input  mem_pkg::addr_t      araddr,
  input  logic                arvalid,
  output logic                arready,

  // Upstream read data channel
  output mem_pkg::data_t      rdata,
  output logic                rvalid,
  input  logic                rready,

  // Upstream write channels
  input  mem_pkg::addr_t      awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  mem_pkg::data_t      wdata,
  input  mem_pkg::strb_t      wstrb,
  input  logic                wvalid,
  output logic                wready,

  // Bank 0
  output mem_pkg::word_addr_t b0_raddr,
  output logic                b0_arvalid,
  input  logic                b0_arready,
  input  mem_pkg::data_t      b0_rdata,
  input  logic                b0_rvalid,
  output logic                b0_rready,
  output logic                b0_we,
  output mem_pkg::word_addr_t b0_waddr,
  output mem_pkg::data_t      b0_wdata,
  output mem_pkg::strb_t      b0_wstrb,

  // Bank 1
  output mem_pkg::word_addr_t b1_raddr,
  output logic                b1_arvalid,
  input  logic                b1_arready,
  input  mem_pkg::data_t      b1_rdata,
  input  logic                b1_rvalid,
  output logic                b1_rready,
  output logic                b1_we,
  output mem_pkg::word_addr_t b1_waddr,
  output mem_pkg::data_t      b1_wdata,
  output mem_pkg::strb_t      b1_wstrb
);

  logic rd_sel;   // bank targeted by the current read request
  logic wr_sel;   // bank targeted by the current write
  logic wr_fire;  // write handshake completes this cycle
  logic rd_bank;  // bank that accepted the last read and owns the response

  assign rd_sel  = araddr[mem_pkg::BANK_SEL_BIT];
  assign wr_sel  = awaddr[mem_pkg::BANK_SEL_BIT];
  assign wr_fire = awvalid && wvalid;

  // Word index is byte-address bits 10:2 for both banks
  assign b0_raddr = araddr[mem_pkg::BANK_SEL_BIT-1:2];
  assign b1_raddr = araddr[mem_pkg::BANK_SEL_BIT-1:2];

  // Response ready only reaches the bank that owns the response
  assign b0_rready = rready && !rd_bank;
  assign b1_rready = rready && rd_bank;

  // A bank arready is high exactly when it holds no response or its
  // response leaves this cycle, so the other bank term doubles as
  // the no-pending-response check that keeps responses in order
  assign arready = b0_arready && b1_arready;

  // Request is only offered to a bank once the upstream side may fire
  assign b0_arvalid = arvalid && arready && !rd_sel;
  assign b1_arvalid = arvalid && arready && rd_sel;

  // Remember which bank will produce the next response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_bank <= 1'b0;
    end else if (arvalid && arready) begin
      rd_bank <= rd_sel;
    end
  end

  // Response mux follows the owning bank
  assign rdata  = rd_bank ? b1_rdata  : b0_rdata;
  assign rvalid = rd_bank ? b1_rvalid : b0_rvalid;

  // Writes never stall
  assign awready = 1'b1;
  assign wready  = 1'b1;

  // Write enable goes to one bank, data and strobes fan out to both
  assign b0_we    = wr_fire && !wr_sel;
  assign b1_we    = wr_fire && wr_sel;
  assign b0_waddr = awaddr[mem_pkg::BANK_SEL_BIT-1:2];
  assign b1_waddr = awaddr[mem_pkg::BANK_SEL_BIT-1:2];
  assign b0_wdata = wdata;
  assign b1_wdata = wdata;
  assign b0_wstrb = wstrb;
  assign b1_wstrb = wstrb;

  // At most one response outstanding across both banks
  a_one_rvalid : assert property (
    @(posedge clk) disable iff (!rst_n) !(b0_rvalid && b1_rvalid)
  ) else $error("mem_port_router: both banks hold a response");

  // Bank write enables are exclusive
  a_one_we : assert property (
    @(posedge clk) disable iff (!rst_n) !(b0_we && b1_we)
  ) else $error("mem_port_router: write sent to both banks");

endmodule

/* src/mem_bram.sv */
`timescale 1ns/10ps

// One block-RAM bank
// Registered read port with one cycle of latency and back-pressure,
// byte-strobed write that lands on the clock edge where we is high
module mem_bram (
  input  logic                clk,
  input  logic                rst_n,

  // Read address already reduced to a word index by the router
  input  mem_pkg::word_addr_t raddr,
  input  logic                arvalid,
  output logic                arready,

  // Read response
  output mem_pkg::data_t      rdata,
  output logic                rvalid,
  input  logic                rready,

  // Write port where we is the combined address and data handshake
  input  logic                we,
  input  mem_pkg::word_addr_t waddr,
  input  mem_pkg::data_t      wdata,
  input  mem_pkg::strb_t      wstrb
);

  // Storage array mapped onto block RAM
  (* ram_style = "block" *)
  mem_pkg::data_t mem [mem_pkg::BANK_WORDS];

  // Output register may load a new word
  // Either nothing is held or the held word leaves this cycle
  logic out_free;

  // Start the array from all zeros
  // Synthesis treats this as the RAM init value
  initial begin
    for (int i = 0; i < mem_pkg::BANK_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign out_free = !rvalid || rready;

  // A new read is taken only when the output register can load it,
  // so a stalled response pushes back on the address channel
  assign arready = out_free;

  // Read output register
  // Word and valid flag load together, and hold while rready is low
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata  <= '0;
      rvalid <= 1'b0;
    end else if (out_free) begin
      // Array is sampled before this edge's write takes effect,
      // so a read and write to one word return the old contents
      rdata  <= mem[raddr];
      rvalid <= arvalid;
    end
  end

  // Byte-strobed write
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
        // Only lanes with their strobe set are touched
        if (wstrb[b]) begin
          mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // A held response must not change until it is consumed
  a_rdata_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> ($stable(rdata) && $stable(rvalid))
  ) else $error("mem_bram: held response changed before rready");

endmodule

/* src/mem_pkg.sv */
package mem_pkg;

  // Width of one data word on the bus and in the banks
  localparam int DATA_W = 32;

  // One strobe per byte lane
  localparam int STRB_W = DATA_W / 8;

  // Bus byte address width
  localparam int ADDR_W = 32;

  // Word address width inside one bank, 512 words
  localparam int BANK_AW = 9;

  // Byte-address bit that picks bank 0 or bank 1
  // Sits just above the word index and the two byte-offset bits
  localparam int BANK_SEL_BIT = BANK_AW + 2;

  // Depth of one bank
  localparam int BANK_WORDS = 2 ** BANK_AW;

  // Data word
  typedef logic [DATA_W-1:0] data_t;

  // Byte strobes for a write
  typedef logic [STRB_W-1:0] strb_t;

  // Bus byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // Word index inside a single bank
  typedef logic [BANK_AW-1:0] word_addr_t;

endpackage
